/* all.f */
rtl/panel_pkg.sv
rtl/timer_if.sv
rtl/heat_ctrl.sv
rtl/phase_timer.sv
rtl/matrix_scan.sv
rtl/heat_panel.sv
tests/tb_heat_panel.sv

/* rtl/heat_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module heat_ctrl
    import panel_pkg::*;
#(
    parameter int HEAT_TICKS = 10,
    parameter int DONE_TICKS = 4,
    parameter int COOL_TICKS = 4
)(
    input  wire    clk,
    input  wire    rst,
    input  wire    start,
    input  wire    stop,
    input  wire    over_temp,
    timer_if.ctrl  tmr,
    output scene_t scene,
    output logic   disp_on,
    output logic   hot
);

    phase_t            phase;
    phase_t            phase_nxt;
    logic [2:0]        flame;
    logic              alt;
    logic              load_nxt;
    logic [TICK_W-1:0] len_nxt;
    logic              expired;

    // an expiry seen while reloading belongs to the phase just left
    assign expired = tmr.expired && !tmr.load;

    always_comb
    begin
        phase_nxt = phase;
        load_nxt  = 1'b0;
        len_nxt   = TICK_W'(HEAT_TICKS);
        case (phase)
            OFF, READY:
            begin
                if (start)
                    phase_nxt = HEAT;
            end
            HEAT:
            begin
                if (over_temp)
                    phase_nxt = FAULT;
                else if (stop)
                    phase_nxt = COOL;
                else if (expired)
                    phase_nxt = DONE;
            end
            DONE:
            begin
                if (stop)
                    phase_nxt = COOL;
                else if (expired)
                    phase_nxt = READY;
            end
            COOL:
            begin
                if (start)
                    phase_nxt = HEAT;
                else if (expired)
                    phase_nxt = READY;
            end
            FAULT:
            begin
                if (stop && !over_temp)
                    phase_nxt = READY;
            end
            default: phase_nxt = OFF;
        endcase

        if (phase_nxt != phase)
        begin
            case (phase_nxt)
                HEAT:
                begin
                    load_nxt = 1'b1;
                    len_nxt  = TICK_W'(HEAT_TICKS);
                end
                DONE:
                begin
                    load_nxt = 1'b1;
                    len_nxt  = TICK_W'(DONE_TICKS);
                end
                COOL:
                begin
                    load_nxt = 1'b1;
                    len_nxt  = TICK_W'(COOL_TICKS);
                end
                default: load_nxt = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            phase    <= OFF;
            flame    <= 3'd0;
            alt      <= 1'b0;
            tmr.load <= 1'b0;
            disp_on  <= 1'b0;
            hot      <= 1'b0;
        end
        else
        begin
            phase    <= phase_nxt;
            tmr.load <= load_nxt;
            disp_on  <= (phase_nxt != OFF);
            hot      <= over_temp;
            if (phase_nxt != phase)
            begin
                flame <= 3'd0;  // each phase starts its animation over
                alt   <= 1'b0;
            end
            else if (tmr.tick)
            begin
                if (phase == HEAT && flame != 3'(FLAME_FULL))
                    flame <= flame + 3'd1;
                alt <= ~alt;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_nxt)
            tmr.load_value <= len_nxt;
    end

    always_comb
    begin
        case (phase)
            HEAT:    scene = scene_t'({1'b0, flame});
            DONE:    scene = alt ? STEAM : DONE_ICON;
            COOL:    scene = alt ? COOL_B : COOL_A;
            READY:   scene = READY_ICON;
            FAULT:   scene = WARN_ICON;
            default: scene = FLAME_0;  // dark anyway
        endcase
    end

    a_no_idle_load: assert property (@(posedge clk) disable iff (rst)
        tmr.load |-> !(phase inside {OFF, FAULT}));

    a_disp_off: assert property (@(posedge clk) disable iff (rst)
        disp_on == (phase != OFF));

endmodule

`default_nettype wire

/* rtl/heat_panel.sv */
`timescale 1ns/1ns
`default_nettype none

module heat_panel
    import panel_pkg::*;
#(
    parameter int CLK_PER_TICK = 8,
    parameter int HEAT_TICKS   = 10,
    parameter int DONE_TICKS   = 4,
    parameter int COOL_TICKS   = 4
)(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   start,
    input  wire                   stop,
    input  wire                   over_temp,
    output wire [MATRIX_ROWS-1:0] row,
    output wire [MATRIX_ROWS-1:0] col_red,
    output wire [MATRIX_ROWS-1:0] col_green
);

    wire scene_t scene;
    wire         disp_on;
    wire         hot;

    timer_if tmr ();

    heat_ctrl #(
        .HEAT_TICKS (HEAT_TICKS),
        .DONE_TICKS (DONE_TICKS),
        .COOL_TICKS (COOL_TICKS)
    ) ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .stop      (stop),
        .over_temp (over_temp),
        .tmr       (tmr.ctrl),
        .scene     (scene),
        .disp_on   (disp_on),
        .hot       (hot)
    );

    phase_timer #(
        .CLK_PER_TICK (CLK_PER_TICK)
    ) timer_i (
        .clk (clk),
        .rst (rst),
        .tmr (tmr.timer)
    );

    matrix_scan scan_i (
        .clk       (clk),
        .rst       (rst),
        .scene     (scene),
        .disp_on   (disp_on),
        .hot       (hot),
        .row       (row),
        .col_red   (col_red),
        .col_green (col_green)
    );

endmodule

`default_nettype wire

/* rtl/matrix_scan.sv */
`timescale 1ns/1ns
`default_nettype none

module matrix_scan
    import panel_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire scene_t             scene,
    input  wire                     disp_on,
    input  wire                     hot,
    output logic [MATRIX_ROWS-1:0]  row,
    output logic [MATRIX_ROWS-1:0]  col_red,
    output logic [MATRIX_ROWS-1:0]  col_green
);

    localparam int BMP_W = MATRIX_ROWS * MATRIX_ROWS;

    scene_t                 scene_q;
    logic [ROW_W-1:0]       row_cnt;
    logic [BMP_W-1:0]       green_bmp;
    logic [BMP_W-1:0]       red_bmp;
    logic [MATRIX_ROWS-1:0] green_byte;
    logic [MATRIX_ROWS-1:0] red_byte;
    logic [MATRIX_ROWS-1:0] red_sel;

    // row 7 in the top byte, row 0 in the bottom byte
    function automatic logic [BMP_W-1:0] green_map(input scene_t s);
        case (s)
            FLAME_0:    green_map = 64'h18_18_00_00_00_00_00_00;
            FLAME_1:    green_map = 64'h3c_18_18_00_00_00_00_00;
            FLAME_2:    green_map = 64'h3c_3c_18_18_00_00_00_00;
            FLAME_3:    green_map = 64'h7e_3c_3c_18_18_00_00_00;
            FLAME_4:    green_map = 64'h7e_7e_3c_3c_18_18_00_00;
            FLAME_FULL: green_map = 64'hff_7e_7e_3c_3c_18_18_08;
            COOL_A:     green_map = 64'h24_18_db_3c_3c_db_18_24;
            COOL_B:     green_map = 64'h00_5a_24_db_db_24_5a_00;
            STEAM:      green_map = 64'h7e_7e_42_00_24_48_24_12;
            READY_ICON: green_map = 64'h00_08_1c_36_63_c1_80_00;
            default:    green_map = '0;
        endcase
    endfunction

    function automatic logic [BMP_W-1:0] red_map(input scene_t s);
        case (s)
            DONE_ICON: red_map = 64'h3c_42_99_a5_81_a5_42_3c;
            WARN_ICON: red_map = 64'h18_00_18_18_18_3c_3c_18;
            default:   red_map = '0;
        endcase
    endfunction

    assign green_bmp  = green_map(scene_q);
    assign red_bmp    = red_map(scene_q);
    assign green_byte = green_bmp[row_cnt * MATRIX_ROWS +: MATRIX_ROWS];
    assign red_byte   = red_bmp[row_cnt * MATRIX_ROWS +: MATRIX_ROWS];

    always_comb
    begin
        case (scene_q)
            DONE_ICON, WARN_ICON:  red_sel = red_byte;
            COOL_A, COOL_B, STEAM: red_sel = green_byte;  // orange regardless of hot
            default:               red_sel = hot ? green_byte : '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scene_q <= FLAME_0;
            row_cnt <= '0;
        end
        else if (!disp_on)
        begin
            scene_q <= FLAME_0;
            row_cnt <= '0;
        end
        else
        begin
            scene_q <= scene;
            if (row_cnt == ROW_W'(MATRIX_ROWS - 1))
                row_cnt <= '0;
            else
                row_cnt <= row_cnt + ROW_W'(1);
        end
    end

    // row select and both column bytes from the same count
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row       <= '1;
            col_green <= '0;
            col_red   <= '0;
        end
        else if (!disp_on)
        begin
            row       <= '1;
            col_green <= '0;
            col_red   <= '0;
        end
        else
        begin
            row       <= ~(MATRIX_ROWS'(1) << row_cnt);  // active low
            col_green <= green_byte;
            col_red   <= red_sel;
        end
    end

    a_row_onehot: assert property (@(posedge clk) disable iff (rst)
        disp_on && $past(disp_on) |-> $onehot(~row));

endmodule

`default_nettype wire

/* rtl/panel_pkg.sv */
`default_nettype none

package panel_pkg;

    localparam int MATRIX_ROWS = 8;
    localparam int ROW_W       = 3;
    localparam int TICK_W      = 16;

    // picture numbers shown on the matrix
    typedef enum logic [3:0] {
        FLAME_0    = 4'd0,
        FLAME_1    = 4'd1,
        FLAME_2    = 4'd2,
        FLAME_3    = 4'd3,
        FLAME_4    = 4'd4,
        FLAME_FULL = 4'd5,
        COOL_A     = 4'd6,
        COOL_B     = 4'd7,
        DONE_ICON  = 4'd8,  // red only
        STEAM      = 4'd9,
        READY_ICON = 4'd10,
        WARN_ICON  = 4'd11  // red only
    } scene_t;

    typedef enum logic [2:0] {
        OFF   = 3'd0,
        HEAT  = 3'd1,
        DONE  = 3'd2,
        COOL  = 3'd3,
        READY = 3'd4,
        FAULT = 3'd5
    } phase_t;

endpackage

`default_nettype wire

/* rtl/phase_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module phase_timer
    import panel_pkg::*;
#(
    parameter int CLK_PER_TICK = 8
)(
    input  wire    clk,
    input  wire    rst,
    timer_if.timer tmr
);

    localparam int PRE_W = (CLK_PER_TICK > 1) ? $clog2(CLK_PER_TICK) : 1;

    logic [PRE_W-1:0]  presc;
    logic [TICK_W-1:0] count;
    logic              running;
    logic              pre_tick;

    assign pre_tick = (presc == PRE_W'(CLK_PER_TICK - 1));

    // free running, a load does not touch it
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            presc <= '0;
        else if (pre_tick)
            presc <= '0;
        else
            presc <= presc + PRE_W'(1);
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tmr.tick    <= 1'b0;
            tmr.expired <= 1'b0;
            count       <= '0;
            running     <= 1'b0;
        end
        else
        begin
            tmr.tick    <= pre_tick;
            tmr.expired <= 1'b0;
            if (tmr.load)
            begin
                count   <= tmr.load_value;
                running <= (tmr.load_value != '0);
            end
            else if (pre_tick && running)
            begin
                count <= count - TICK_W'(1);
                if (count == TICK_W'(1))
                begin
                    running     <= 1'b0;  // idle until next load
                    tmr.expired <= 1'b1;
                end
            end
        end
    end

    a_exp_on_tick: assert property (@(posedge clk) disable iff (rst)
        tmr.expired |-> tmr.tick);

endmodule

`default_nettype wire

/* rtl/timer_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface timer_if
    import panel_pkg::*;
();
    logic              load;
    logic [TICK_W-1:0] load_value;
    logic              tick;
    logic              expired;

    modport ctrl (
        output load,
        output load_value,
        input  tick,
        input  expired
    );

    modport timer (
        input  load,
        input  load_value,
        output tick,
        output expired
    );
endinterface

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
    --top-module tb_heat_panel -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_heat_panel)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Done: no errors$"; then
    exit 0
fi
exit 1

/* tests/heat_panel_tests.txt */
# T scene hot, then green bytes for rows 0..7, then red bytes for rows 0..7 (hex)
# R command count, then the scene codes expected after the command, in order
# scenes 0-4 flame steps, 5 full flame, 6 7 cooling, 8 done, 9 steam, 10 ready, 11 warning
T 0 0 00 00 00 00 00 00 18 18 00 00 00 00 00 00 00 00
T 0 1 00 00 00 00 00 00 18 18 00 00 00 00 00 00 18 18
T 1 0 00 00 00 00 00 18 18 3c 00 00 00 00 00 00 00 00
T 1 1 00 00 00 00 00 18 18 3c 00 00 00 00 00 18 18 3c
T 2 0 00 00 00 00 18 18 3c 3c 00 00 00 00 00 00 00 00
T 2 1 00 00 00 00 18 18 3c 3c 00 00 00 00 18 18 3c 3c
T 3 0 00 00 00 18 18 3c 3c 7e 00 00 00 00 00 00 00 00
T 3 1 00 00 00 18 18 3c 3c 7e 00 00 00 18 18 3c 3c 7e
T 4 0 00 00 18 18 3c 3c 7e 7e 00 00 00 00 00 00 00 00
T 4 1 00 00 18 18 3c 3c 7e 7e 00 00 18 18 3c 3c 7e 7e
T 5 0 08 18 18 3c 3c 7e 7e ff 00 00 00 00 00 00 00 00
T 5 1 08 18 18 3c 3c 7e 7e ff 08 18 18 3c 3c 7e 7e ff
T 6 0 24 18 db 3c 3c db 18 24 24 18 db 3c 3c db 18 24
T 6 1 24 18 db 3c 3c db 18 24 24 18 db 3c 3c db 18 24
T 7 0 00 5a 24 db db 24 5a 00 00 5a 24 db db 24 5a 00
T 7 1 00 5a 24 db db 24 5a 00 00 5a 24 db db 24 5a 00
T 8 0 00 00 00 00 00 00 00 00 3c 42 a5 81 a5 99 42 3c
T 8 1 00 00 00 00 00 00 00 00 3c 42 a5 81 a5 99 42 3c
T 9 0 12 24 48 24 00 42 7e 7e 12 24 48 24 00 42 7e 7e
T 9 1 12 24 48 24 00 42 7e 7e 12 24 48 24 00 42 7e 7e
T 10 0 00 80 c1 63 36 1c 08 00 00 00 00 00 00 00 00 00
T 10 1 00 80 c1 63 36 1c 08 00 00 80 c1 63 36 1c 08 00
T 11 0 00 00 00 00 00 00 00 00 18 3c 3c 18 18 18 00 18
T 11 1 00 00 00 00 00 00 00 00 18 3c 3c 18 18 18 00 18
R start 15 0 1 2 3 4 5 5 5 5 5 8 9 8 9 10
R start 3 0 1 2
R stop 5 6 7 6 7 10
R start 2 0 1
R temp_on 1 11
R stop 3 11 11 11
R temp_off 2 11 11
R stop 1 10
R temp_on 2 10 10
R temp_off 2 10 10
R start 15 0 1 2 3 4 5 5 5 5 5 8 9 8 9 10

/* tests/tb_heat_panel.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_heat_panel;

    localparam int CLK_PER_TICK = 8;
    localparam int HEAT_TICKS   = 10;
    localparam int DONE_TICKS   = 4;
    localparam int COOL_TICKS   = 4;
    localparam int N_SCENES     = 12;
    localparam int MAX_RECS     = 16;
    localparam int MAX_EXP      = 16;
    localparam int WAIT_FRAMES  = 4;   // one frame per tick at this prescale
    // start then lands two clocks after a prescaler wrap, so frames line up with ticks
    localparam int OFF_CYCLES   = 33;

    logic       clk;
    logic       rst;
    logic       start;
    logic       stop;
    logic       over_temp;
    logic [7:0] row;
    logic [7:0] col_red;
    logic [7:0] col_green;

    logic [7:0] green_tab [0:2*N_SCENES-1][0:7];  // index scene*2 + hot
    logic [7:0] red_tab   [0:2*N_SCENES-1][0:7];
    string      rec_cmd   [0:MAX_RECS-1];
    int         rec_len   [0:MAX_RECS-1];
    int         rec_exp   [0:MAX_RECS-1][0:MAX_EXP-1];
    logic [7:0] frame_g   [0:7];
    logic [7:0] frame_r   [0:7];
    int         n_recs;
    int         errors;
    int         test_errs;
    int         tests_run;
    int         tests_failed;
    int         cycles      = 0;
    int         cycle_limit = 0;

    heat_panel #(
        .CLK_PER_TICK (CLK_PER_TICK),
        .HEAT_TICKS   (HEAT_TICKS),
        .DONE_TICKS   (DONE_TICKS),
        .COOL_TICKS   (COOL_TICKS)
    ) heat_panel_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .stop      (stop),
        .over_temp (over_temp),
        .row       (row),
        .col_red   (col_red),
        .col_green (col_green)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("Timeout: run stopped after %0d cycles, an expected scene never came",
                     cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic load_file(output int ok);
        int    fd;
        int    code;
        int    c;
        int    s;
        int    h;
        int    n;
        int    i;
        int    n_tab;
        string tok;
        string word;
        ok     = 0;
        n_tab  = 0;
        n_recs = 0;
        fd = $fopen("tests/heat_panel_tests.txt", "r");
        if (fd == 0)
            $display("Could not open tests/heat_panel_tests.txt");
        else
        begin
            code = $fscanf(fd, "%s", tok);
            while (code == 1)
            begin
                if (tok == "#")
                begin
                    c = $fgetc(fd);
                    while (c != 10 && c != -1)
                        c = $fgetc(fd);
                end
                else if (tok == "T")
                begin
                    code = $fscanf(fd, "%d %d", s, h);
                    for (i = 0; i < 8; i++)
                        code = $fscanf(fd, "%h", green_tab[2*s+h][i]);
                    for (i = 0; i < 8; i++)
                        code = $fscanf(fd, "%h", red_tab[2*s+h][i]);
                    n_tab++;
                end
                else if (tok == "R" && n_recs < MAX_RECS)
                begin
                    code = $fscanf(fd, "%s %d", word, n);
                    rec_cmd[n_recs] = word;
                    rec_len[n_recs] = (n > MAX_EXP) ? MAX_EXP : n;
                    for (i = 0; i < rec_len[n_recs]; i++)
                        code = $fscanf(fd, "%d", rec_exp[n_recs][i]);
                    n_recs++;
                end
                code = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
            if (n_tab == 2 * N_SCENES && n_recs > 0)
                ok = 1;
            else
                $display("Data file incomplete: %0d table lines, %0d records", n_tab, n_recs);
        end
    endtask

    // one frame from the row-0 select on
    task automatic capture_frame();
        int i;
        @(negedge clk);
        while (row != 8'hfe)
            @(negedge clk);
        for (i = 0; i < 8; i++)
        begin
            if (i > 0)
                @(negedge clk);
            if (row != ~(8'h01 << i))
            begin
                $display("FAIL at %0t: row select %h out of order at row %0d", $time, row, i);
                test_errs++;
            end
            frame_g[i] = col_green;
            frame_r[i] = col_red;
        end
    endtask

    function automatic int match_frame(input int hot);
        int s;
        int i;
        bit same;
        match_frame = -1;
        for (s = 0; s < N_SCENES; s++)
        begin
            same = 1'b1;
            for (i = 0; i < 8; i++)
            begin
                if (frame_g[i] != green_tab[2*s+hot][i] || frame_r[i] != red_tab[2*s+hot][i])
                    same = 1'b0;
            end
            if (same)
                match_frame = s;
        end
    endfunction

    task automatic apply_cmd(input string cmd);
        if (row != 8'hff)
        begin
            // strobe is sampled just before the next frame starts
            do
                @(negedge clk);
            while (row != 8'hfe);
            repeat (5) @(negedge clk);
        end
        if (cmd == "start")
            start = 1'b1;
        else if (cmd == "stop")
            stop = 1'b1;
        else if (cmd == "temp_on")
            over_temp = 1'b1;
        else if (cmd == "temp_off")
            over_temp = 1'b0;
        else
        begin
            $display("FAIL at %0t: unknown command %s in data file", $time, cmd);
            test_errs++;
        end
        @(negedge clk);
        start = 1'b0;
        stop  = 1'b0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        errors += test_errs;
        if (test_errs == 0)
            $display("%s: ok", name);
        else
        begin
            tests_failed++;
            $display("%s: %0d errors", name, test_errs);
        end
    endtask

    task automatic check_dark();
        int i;
        test_errs = 0;
        for (i = 0; i < OFF_CYCLES; i++)
        begin
            @(negedge clk);
            if (row != 8'hff || col_green != 8'h00 || col_red != 8'h00)
            begin
                $display("FAIL at %0t: display lit while off, row %h green %h red %h",
                         $time, row, col_green, col_red);
                test_errs++;
            end
        end
        end_test("test 1 off dark");
    endtask

    task automatic run_record(input int r);
        int k;
        int m;
        int frames;
        int hot_exp;
        bit found;
        test_errs = 0;
        apply_cmd(rec_cmd[r]);
        hot_exp = over_temp ? 1 : 0;  // hot follows the level
        for (k = 0; k < rec_len[r]; k++)
        begin
            found  = 1'b0;
            frames = 0;
            while (!found && frames < WAIT_FRAMES)
            begin
                capture_frame();
                frames++;
                m = match_frame(hot_exp);
                if (m == rec_exp[r][k])
                    found = 1'b1;
                else if (m >= 0)
                begin
                    $display("FAIL at %0t: scene %0d shown, scene %0d expected",
                             $time, m, rec_exp[r][k]);
                    test_errs++;
                end
            end
            if (!found)
            begin
                $display("FAIL at %0t: scene %0d not shown within %0d ticks",
                         $time, rec_exp[r][k], WAIT_FRAMES);
                test_errs++;
            end
        end
        end_test($sformatf("test %0d %s", r + 2, rec_cmd[r]));
    endtask

    initial
    begin
        int ok;
        int r;
        int budget;
        rst          = 1'b1;
        start        = 1'b0;
        stop         = 1'b0;
        over_temp    = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        load_file(ok);
        if (ok == 1)
        begin
            budget = 0;
            for (r = 0; r < n_recs; r++)
                budget += (rec_len[r] + 1) * WAIT_FRAMES * CLK_PER_TICK;
            cycle_limit = 16 + OFF_CYCLES + (budget * 3) / 2;
            repeat (16) @(negedge clk);
            rst = 1'b0;
            check_dark();
            for (r = 0; r < n_recs; r++)
                run_record(r);
        end
        else
            errors++;
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire
